// File: verilog.f
+incdir+source
source/pipe_pkg.sv
source/stage_fetch.sv
source/stage_decode.sv
source/stage_execute.sv
source/stage_memory.sv
source/pipeline.sv
tests/pipeline_assert.sv
tests/pipeline_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module pipeline_tb -o pipeline_sim

out=$(./obj_dir/pipeline_sim) || { echo "$out"; exit 1; }
echo "$out"

if echo "$out" | grep -q "TESTBENCH PASSED"; then
    exit 0
else
    exit 1
fi

// File: tests/pipeline_tb.sv
// Two random programs of 48 instructions, the first ending in WFI, the second illegal
// Memory is 256 words, combinational, reloaded from the image during reset
// Data accesses stay in 0x200..0x23C, programs start at 0
`include "pipe_defs.svh"

module pipeline_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CYCLE_LIMIT = 600;
    localparam int PROG_LEN    = 48;

    logic clock = 1'b0;
    logic reset = 1'b1;
    logic [`XLEN-1:0] mem2proc_data;
    pipe_pkg::bus_command_e proc2mem_command;
    logic [`XLEN-1:0] proc2mem_addr, proc2mem_data, commit_wr_data, commit_pc;
    logic commit_valid, commit_wr_en;
    logic [4:0] commit_wr_idx;
    pipe_pkg::error_status_e error_status;

    logic [`XLEN-1:0] mem [256];
    logic [`XLEN-1:0] image [256];
    logic [31:0] lfsr = 32'h4157;
    logic [`XLEN-1:0] exp_pc[$], exp_data[$];
    logic exp_wr_en[$];
    logic [4:0] exp_idx[$];
    pipe_pkg::error_status_e exp_code;
    int ptr = 0;
    int cycles = 0;

    pipeline dut (.*);

    initial forever #4 clock = ~clock;

    // Memory model, loads the image while in reset
    assign mem2proc_data = mem[proc2mem_addr[9:2]];
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 256; i++)
                mem[i] <= image[i];
        end else if (proc2mem_command == pipe_pkg::bus_store) begin
            mem[proc2mem_addr[9:2]] <= proc2mem_data;
        end
    end

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic compare(input string name, input logic [31:0] expv, input logic [31:0] got);
        if (got !== expv)
            stop_with_failure($sformatf("Fail %0t %s expected %h got %h", $time, name, expv, got));
    endtask

    ////////////////////////////////////////
    // Commit checks and timeout
    ////////////////////////////////////////

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT)
            stop_with_failure("Timeout: programs did not halt within the cycle limit");
        if (dut.checks.any_failed)
            stop_with_failure("A bound assertion on the pipeline failed");
        if (reset) begin
            ptr = 0;
        end else if (commit_valid) begin
            if (ptr >= exp_pc.size())
                stop_with_failure("A commit arrived after the halting instruction");
            compare("commit_pc", exp_pc[ptr], commit_pc);
            compare("commit_wr_en", 32'(exp_wr_en[ptr]), 32'(commit_wr_en));
            if (exp_wr_en[ptr]) begin
                compare("commit_wr_idx", 32'(exp_idx[ptr]), 32'(commit_wr_idx));
                compare("commit_wr_data", exp_data[ptr], commit_wr_data);
            end
            // Only the last commit carries a halt code
            if (ptr == exp_pc.size() - 1)
                compare("error_status", 32'(exp_code), 32'(error_status));
            else
                compare("error_status", 32'(pipe_pkg::no_error), 32'(error_status));
            ptr = ptr + 1;
        end
    end

    ////////////////////////////////////////
    // Random program builder
    ////////////////////////////////////////

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // Half the time reuse the last destination for dense dependencies
    task automatic pick_reg(input logic [4:0] last, output logic [4:0] idx);
        logic [31:0] r;
        take_bits(1, r);
        if (r[0]) begin
            idx = last;
        end else begin
            take_bits(3, r);
            idx = 5'(r % 7 + 1);
        end
    endtask

    task automatic push_commit(input int i, input logic en, input logic [4:0] rd,
                               input logic [31:0] val);
        exp_pc.push_back(32'(i * `PC_STEP));
        exp_wr_en.push_back(en);
        exp_idx.push_back(rd);
        exp_data.push_back(val);
    endtask

    task automatic build_program(input logic end_on_wfi);
        logic [31:0] regs [8];
        logic [31:0] data [16];
        logic [31:0] r, val;
        logic [4:0] rd, rs1, rs2, last;
        logic [11:0] imm, offs;
        exp_pc.delete();
        exp_wr_en.delete();
        exp_idx.delete();
        exp_data.delete();
        last = 5'd1;
        // Fill depends on every address bit
        for (int i = 0; i < 256; i++)
            image[i] = (32'h9e37_79b9 * 32'(i + 1)) ^ 32'(i);
        for (int k = 0; k < 16; k++)
            data[k] = image[128 + k];
        for (int i = 0; i < PROG_LEN; i++) begin
            take_bits(12, r);
            imm = r[11:0];
            if (i < 7) begin
                // ADDI xi, x0, imm sets a known start value
                rd = 5'(i + 1);
                image[i] = {imm, 5'd0, pipe_pkg::FUNCT3_ADD, rd, pipe_pkg::OP_IMM};
                val = {{20{imm[11]}}, imm};
            end else begin
                take_bits(3, r);
                pick_reg(last, rs1);
                pick_reg(last, rs2);
                take_bits(3, val);
                rd = 5'(val % 7 + 1);
                take_bits(4, val);
                // Word offset into the data window
                offs = 12'h200 + 12'(val[3:0] * 4);
                case (r[2:0])
                    3'd0, 3'd1: begin
                        image[i] = {imm, rs1, pipe_pkg::FUNCT3_ADD, rd, pipe_pkg::OP_IMM};
                        val = regs[rs1] + {{20{imm[11]}}, imm};
                    end
                    3'd2: begin
                        image[i] = {pipe_pkg::FUNCT7_ADD, rs2, rs1, pipe_pkg::FUNCT3_ADD,
                                    rd, pipe_pkg::OP};
                        val = regs[rs1] + regs[rs2];
                    end
                    3'd3, 3'd4: begin
                        image[i] = {pipe_pkg::FUNCT7_SUB, rs2, rs1, pipe_pkg::FUNCT3_ADD,
                                    rd, pipe_pkg::OP};
                        val = regs[rs1] - regs[rs2];
                    end
                    3'd5: begin
                        image[i] = {offs, 5'd0, pipe_pkg::FUNCT3_WORD, rd, pipe_pkg::LOAD};
                        val = data[offs[5:2]];
                    end
                    default: begin
                        // SW rs2, offs(x0), no register write
                        image[i] = {offs[11:5], rs2, 5'd0, pipe_pkg::FUNCT3_WORD, offs[4:0],
                                    pipe_pkg::STORE};
                        data[offs[5:2]] = regs[rs2];
                        rd = 5'd0;
                    end
                endcase
            end
            if (rd != 5'd0) begin
                regs[rd] = val;
                last = rd;
            end
            push_commit(i, rd != 5'd0, rd, val);
        end
        image[PROG_LEN] = end_on_wfi ? pipe_pkg::WFI_WORD : 32'hffff_ffff;
        exp_code = end_on_wfi ? pipe_pkg::halted_on_wfi : pipe_pkg::illegal_inst;
        push_commit(PROG_LEN, 1'b0, 5'd0, '0);
    endtask

    task automatic run_program(input logic end_on_wfi);
        @(posedge clock);
        reset <= 1'b1;
        build_program(end_on_wfi);
        repeat (4) @(posedge clock);
        reset <= 1'b0;
        // Commit checker advances ptr, timeout bounds the wait
        @(posedge clock);
        while (ptr < exp_pc.size())
            @(posedge clock);
        repeat (10) @(posedge clock);
        compare("error_status", 32'(exp_code), 32'(error_status));
    endtask

    initial begin
        run_program(1'b1);
        run_program(1'b0);
        if (dut.checks.any_failed) begin
            stop_with_failure("A bound assertion on the pipeline failed");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

// File: tests/pipeline_assert.sv
// Concurrent checks on the pipeline top level, bound to every pipeline instance
// Each property raises its own sticky flag, any_failed is their OR
`include "pipe_defs.svh"

module pipeline_assert (
    input logic                    clock,
    input logic                    reset,
    input pipe_pkg::bus_command_e  proc2mem_command,
    input logic [`XLEN-1:0]        proc2mem_addr,
    input pipe_pkg::bus_command_e  dmem_command,
    input logic [`XLEN-1:0]        fetch_pc,
    input logic                    commit_valid,
    input logic                    commit_wr_en,
    input logic [`XLEN-1:0]        commit_pc,
    input pipe_pkg::error_status_e error_status,
    output logic                   any_failed
);
    timeunit 1ns;
    timeprecision 1ps;

    bit reset_bad, order_bad, bus_bad, halt_bad, hold_bad;
    bit have_last;
    logic [`XLEN-1:0] last_pc;

    assign any_failed = reset_bad | order_bad | bus_bad | halt_bad | hold_bad;

    // Last committed PC, cleared by reset
    always_ff @(posedge clock) begin
        if (reset) begin
            have_last <= 1'b0;
        end else if (commit_valid) begin
            have_last <= 1'b1;
            last_pc   <= commit_pc;
        end
    end

    ////////////////////////////////////////
    // Reset state and ordering
    ////////////////////////////////////////

    assert property (@(posedge clock) $past(reset) && !reset |->
        !commit_valid && !commit_wr_en && error_status == pipe_pkg::no_error &&
        proc2mem_command == pipe_pkg::bus_load && proc2mem_addr == '0)
    else begin
        reset_bad = 1'b1;
        $error("state after reset is wrong");
    end

    assert property (@(posedge clock) disable iff (reset)
        commit_valid && have_last |-> commit_pc == last_pc + `XLEN'(`PC_STEP))
    else begin
        order_bad = 1'b1;
        $error("commit_pc did not step by 4");
    end

    // Data access owns the bus, so the fetch PC must not move
    assert property (@(posedge clock) disable iff (reset)
        dmem_command != pipe_pkg::bus_none |=> fetch_pc == $past(fetch_pc))
    else begin
        bus_bad = 1'b1;
        $error("fetch advanced during a data access");
    end

    ////////////////////////////////////////
    // Halting
    ////////////////////////////////////////

    assert property (@(posedge clock) disable iff (reset)
        error_status != pipe_pkg::no_error |=> !commit_valid)
    else begin
        halt_bad = 1'b1;
        $error("commit after halt");
    end

    assert property (@(posedge clock) disable iff (reset)
        error_status != pipe_pkg::no_error |=> error_status == $past(error_status))
    else begin
        hold_bad = 1'b1;
        $error("error_status changed before reset");
    end

endmodule

bind pipeline pipeline_assert checks (
    .clock(clock), .reset(reset),
    .proc2mem_command(proc2mem_command), .proc2mem_addr(proc2mem_addr),
    .dmem_command(dmem_command), .fetch_pc(fetch_pc),
    .commit_valid(commit_valid), .commit_wr_en(commit_wr_en),
    .commit_pc(commit_pc), .error_status(error_status),
    .any_failed()
);

// File: source/pipeline.sv
// Top of the five-stage pipeline with one shared memory port
// Memory stage has priority over fetch on the bus
// After an illegal word or WFI commits, the machine waits for reset
`include "pipe_defs.svh"

module pipeline (
    input  logic                    clock,
    input  logic                    reset,
    input  logic [`XLEN-1:0]        mem2proc_data,
    output pipe_pkg::bus_command_e  proc2mem_command,
    output logic [`XLEN-1:0]        proc2mem_addr,
    output logic [`XLEN-1:0]        proc2mem_data,
    output logic                    commit_valid,
    output logic                    commit_wr_en,
    output logic [4:0]              commit_wr_idx,
    output logic [`XLEN-1:0]        commit_wr_data,
    output logic [`XLEN-1:0]        commit_pc,
    output pipe_pkg::error_status_e error_status
);

    // Fetch and IF/ID
    logic bus_granted, stall, freeze, if_valid;
    logic [`XLEN-1:0] fetch_pc, if_pc, if_inst;

    // ID/EX
    logic id_valid, id_wr_en;
    logic [4:0] id_rd;
    logic [`XLEN-1:0] id_pc, id_opa, id_opb, id_store_data;
    pipe_pkg::alu_op_e id_alu_op;
    pipe_pkg::bus_command_e id_mem_cmd;
    pipe_pkg::error_status_e id_error;
    logic [`XLEN-1:0] ex_result;

    // EX/MEM
    logic ex_mem_valid, ex_mem_wr_en;
    logic [4:0] ex_mem_rd;
    logic [`XLEN-1:0] ex_mem_pc, ex_mem_result, ex_mem_store_data;
    pipe_pkg::bus_command_e ex_mem_cmd;
    pipe_pkg::error_status_e ex_mem_error;

    // Memory stage and MEM/WB
    pipe_pkg::bus_command_e dmem_command;
    logic [`XLEN-1:0] dmem_addr, dmem_data, mem_result;
    logic mem_wb_valid, mem_wb_wr_en;
    logic [4:0] mem_wb_rd;
    logic [`XLEN-1:0] mem_wb_pc, mem_wb_data;
    pipe_pkg::error_status_e mem_wb_error, halt_code;

    stage_fetch fetch (
        .clock(clock), .reset(reset),
        .bus_granted(bus_granted), .stall(stall), .freeze(freeze),
        .fetch_data(mem2proc_data), .fetch_pc(fetch_pc),
        .if_valid(if_valid), .if_pc(if_pc), .if_inst(if_inst)
    );

    // Write port comes straight from MEM/WB
    stage_decode decode (
        .clock(clock), .reset(reset),
        .if_valid(if_valid), .if_pc(if_pc), .if_inst(if_inst),
        .wb_en(commit_wr_en), .wb_idx(mem_wb_rd), .wb_data(mem_wb_data),
        .mem_dest_valid(ex_mem_valid && ex_mem_wr_en), .mem_dest_idx(ex_mem_rd),
        .stall(stall), .freeze(freeze),
        .id_valid(id_valid), .id_pc(id_pc), .id_rd(id_rd), .id_wr_en(id_wr_en),
        .id_alu_op(id_alu_op), .id_opa(id_opa), .id_opb(id_opb),
        .id_store_data(id_store_data), .id_mem_cmd(id_mem_cmd), .id_error(id_error)
    );

    stage_execute execute (
        .id_alu_op(id_alu_op), .id_opa(id_opa), .id_opb(id_opb),
        .id_mem_cmd(id_mem_cmd), .ex_result(ex_result)
    );

    stage_memory memory (
        .mem_valid(ex_mem_valid), .mem_cmd(ex_mem_cmd),
        .mem_addr(ex_mem_result), .mem_store_data(ex_mem_store_data),
        .mem2proc_data(mem2proc_data),
        .dmem_command(dmem_command), .dmem_addr(dmem_addr), .dmem_data(dmem_data),
        .mem_result(mem_result)
    );

    ////////////////////////////////////////
    // Pipeline registers
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            ex_mem_valid <= 1'b0;
            mem_wb_valid <= 1'b0;
            halt_code    <= pipe_pkg::no_error;
        end else begin
            ex_mem_valid <= id_valid;
            mem_wb_valid <= ex_mem_valid;
            // First halting commit sets the code until reset
            if (mem_wb_valid && halt_code == pipe_pkg::no_error)
                halt_code <= mem_wb_error;
        end
    end

    // Payload travels with the valid bits, no reset needed
    always_ff @(posedge clock) begin
        ex_mem_pc         <= id_pc;
        ex_mem_rd         <= id_rd;
        ex_mem_wr_en      <= id_wr_en;
        ex_mem_result     <= ex_result;
        ex_mem_store_data <= id_store_data;
        ex_mem_cmd        <= id_mem_cmd;
        ex_mem_error      <= id_error;
        mem_wb_pc         <= ex_mem_pc;
        mem_wb_rd         <= ex_mem_rd;
        mem_wb_wr_en      <= ex_mem_wr_en;
        mem_wb_data       <= mem_result;
        mem_wb_error      <= ex_mem_error;
    end

    ////////////////////////////////////////
    // Bus arbitration
    ////////////////////////////////////////

    // Data access first, otherwise fetch at the PC
    assign bus_granted      = dmem_command == pipe_pkg::bus_none;
    assign proc2mem_command = bus_granted ? pipe_pkg::bus_load : dmem_command;
    assign proc2mem_addr    = bus_granted ? fetch_pc : dmem_addr;
    assign proc2mem_data    = dmem_data;

    // Commit and write-back
    assign commit_valid   = mem_wb_valid;
    assign commit_wr_en   = mem_wb_valid && mem_wb_wr_en;
    assign commit_wr_idx  = mem_wb_rd;
    assign commit_wr_data = mem_wb_data;
    assign commit_pc      = mem_wb_pc;
    // Code shows in the commit cycle, then holds
    assign error_status = (halt_code != pipe_pkg::no_error) ? halt_code :
                          (mem_wb_valid ? mem_wb_error : pipe_pkg::no_error);

endmodule

// File: source/stage_memory.sv
// Data side of the shared memory port
// Memory answers in the same cycle, so loads finish here
`include "pipe_defs.svh"

module stage_memory (
    input  logic                   mem_valid,
    input  pipe_pkg::bus_command_e mem_cmd,
    input  logic [`XLEN-1:0]       mem_addr,
    input  logic [`XLEN-1:0]       mem_store_data,
    input  logic [`XLEN-1:0]       mem2proc_data,
    output pipe_pkg::bus_command_e dmem_command,
    output logic [`XLEN-1:0]       dmem_addr,
    output logic [`XLEN-1:0]       dmem_data,
    output logic [`XLEN-1:0]       mem_result
);

    logic is_load;

    assign is_load = mem_valid && mem_cmd == pipe_pkg::bus_load;

    // Request only for a valid load or store
    assign dmem_command = mem_valid ? mem_cmd : pipe_pkg::bus_none;
    assign dmem_addr    = mem_addr;
    assign dmem_data    = mem_store_data;

    // Load data, otherwise the ALU value passes on
    assign mem_result = is_load ? mem2proc_data : mem_addr;

endmodule

// File: source/stage_execute.sv
// Combinational ALU for the instruction held in ID/EX
// Loads and stores always add, giving a byte address
`include "pipe_defs.svh"

module stage_execute (
    input  pipe_pkg::alu_op_e      id_alu_op,
    input  logic [`XLEN-1:0]       id_opa,
    input  logic [`XLEN-1:0]       id_opb,
    input  pipe_pkg::bus_command_e id_mem_cmd,
    output logic [`XLEN-1:0]       ex_result
);

    logic [`XLEN-1:0] sum;
    logic [`XLEN-1:0] diff;

    assign sum  = id_opa + id_opb;
    assign diff = id_opa - id_opb;

    always_comb begin
        case (id_mem_cmd)
            // Effective address, base plus offset
            pipe_pkg::bus_load,
            pipe_pkg::bus_store: ex_result = sum;
            default: begin
                if (id_alu_op == pipe_pkg::alu_sub)
                    ex_result = diff;
                else
                    ex_result = sum;
            end
        endcase
    end

endmodule

// File: source/stage_decode.sv
// Decode, register file and ID/EX register
// No forwarding: sources stall against ID/EX and EX/MEM destinations
// The MEM/WB write reaches a same-cycle read through the bypass
`include "pipe_defs.svh"

module stage_decode (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     if_valid,
    input  logic [`XLEN-1:0]         if_pc,
    input  logic [`XLEN-1:0]         if_inst,
    input  logic                     wb_en,
    input  logic [4:0]               wb_idx,
    input  logic [`XLEN-1:0]         wb_data,
    input  logic                     mem_dest_valid,
    input  logic [4:0]               mem_dest_idx,
    output logic                     stall,
    output logic                     freeze,
    output logic                     id_valid,
    output logic [`XLEN-1:0]         id_pc,
    output logic [4:0]               id_rd,
    output logic                     id_wr_en,
    output pipe_pkg::alu_op_e        id_alu_op,
    output logic [`XLEN-1:0]         id_opa,
    output logic [`XLEN-1:0]         id_opb,
    output logic [`XLEN-1:0]         id_store_data,
    output pipe_pkg::bus_command_e   id_mem_cmd,
    output pipe_pkg::error_status_e  id_error
);

    pipe_pkg::instr_word_u inst;
    logic [`XLEN-1:0] regs [`REG_COUNT];
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic is_addi, is_add, is_sub, is_lw, is_sw, is_wfi, is_legal;
    logic uses_rs1, uses_rs2, writes_rd, issue;
    logic [`XLEN-1:0] rs1_val, rs2_val, imm_i, imm_s;

    // Read with x0 forced to zero and write-through bypass
    function automatic logic [`XLEN-1:0] read_reg(input logic [4:0] idx);
        if (idx == 5'd0)
            return '0;
        else if (wb_en && wb_idx == idx)
            return wb_data;
        else
            return regs[idx];
    endfunction

    // Source waits on an older writer still in flight
    function automatic logic conflicts(input logic [4:0] src);
        return (src != 5'd0) &&
               ((id_valid && id_wr_en && id_rd == src) ||
                (mem_dest_valid && mem_dest_idx == src));
    endfunction

    ////////////////////////////////////////
    // Field decode
    ////////////////////////////////////////

    assign inst   = if_inst;
    assign opcode = inst.r_form.opcode;
    assign funct3 = inst.r_form.funct3;

    assign is_addi = opcode == pipe_pkg::OP_IMM && inst.i_form.funct3 == pipe_pkg::FUNCT3_ADD;
    assign is_add  = opcode == pipe_pkg::OP && funct3 == pipe_pkg::FUNCT3_ADD &&
                     inst.r_form.funct7 == pipe_pkg::FUNCT7_ADD;
    assign is_sub  = opcode == pipe_pkg::OP && funct3 == pipe_pkg::FUNCT3_ADD &&
                     inst.r_form.funct7 == pipe_pkg::FUNCT7_SUB;
    assign is_lw   = opcode == pipe_pkg::LOAD && inst.i_form.funct3 == pipe_pkg::FUNCT3_WORD;
    assign is_sw   = opcode == pipe_pkg::STORE && inst.s_form.funct3 == pipe_pkg::FUNCT3_WORD;
    assign is_wfi  = if_inst == pipe_pkg::WFI_WORD;
    // Anything outside the subset halts as illegal
    assign is_legal = is_addi | is_add | is_sub | is_lw | is_sw | is_wfi;

    assign uses_rs1  = is_addi | is_add | is_sub | is_lw | is_sw;
    assign uses_rs2  = is_add | is_sub | is_sw;
    assign writes_rd = (is_addi | is_add | is_sub | is_lw) && inst.r_form.rd != 5'd0;

    // Sign-extended I and S immediates
    assign imm_i = {{(`XLEN-12){inst.i_form.imm[11]}}, inst.i_form.imm};
    assign imm_s = {{(`XLEN-12){inst.s_form.imm_hi[6]}}, inst.s_form.imm_hi, inst.s_form.imm_lo};

    assign rs1_val = read_reg(inst.r_form.rs1);
    assign rs2_val = read_reg(inst.r_form.rs2);

    // Hazard stall and issue
    assign stall = if_valid && ((uses_rs1 && conflicts(inst.r_form.rs1)) ||
                                (uses_rs2 && conflicts(inst.r_form.rs2)));
    assign issue = if_valid && !stall && !freeze;

    ////////////////////////////////////////
    // Register file write port
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (wb_en && wb_idx != 5'd0)
            regs[wb_idx] <= wb_data;
    end

    ////////////////////////////////////////
    // ID/EX register
    ////////////////////////////////////////

    // Control half, bubble when not issuing
    always_ff @(posedge clock) begin
        if (reset) begin
            id_valid   <= 1'b0;
            id_wr_en   <= 1'b0;
            id_mem_cmd <= pipe_pkg::bus_none;
            id_error   <= pipe_pkg::no_error;
            freeze     <= 1'b0;
        end else begin
            id_valid <= issue;
            id_wr_en <= issue && writes_rd;
            if (!issue)
                id_mem_cmd <= pipe_pkg::bus_none;
            else if (is_lw)
                id_mem_cmd <= pipe_pkg::bus_load;
            else if (is_sw)
                id_mem_cmd <= pipe_pkg::bus_store;
            else
                id_mem_cmd <= pipe_pkg::bus_none;
            if (!issue)
                id_error <= pipe_pkg::no_error;
            else if (!is_legal)
                id_error <= pipe_pkg::illegal_inst;
            else if (is_wfi)
                id_error <= pipe_pkg::halted_on_wfi;
            else
                id_error <= pipe_pkg::no_error;
            // Sticky until reset
            if (issue && (is_wfi || !is_legal))
                freeze <= 1'b1;
        end
    end

    // Payload half, only meaningful with id_valid
    always_ff @(posedge clock) begin
        if (issue) begin
            id_pc         <= if_pc;
            id_rd         <= inst.r_form.rd;
            id_alu_op     <= is_sub ? pipe_pkg::alu_sub : pipe_pkg::alu_add;
            id_opa        <= rs1_val;
            id_opb        <= (is_add | is_sub) ? rs2_val : (is_sw ? imm_s : imm_i);
            id_store_data <= rs2_val;
        end
    end

endmodule

// File: source/stage_fetch.sv
// PC register and IF/ID register
// Sequential fetch only, the PC never branches
// A cycle without the bus leaves an invalid bubble in IF/ID
`include "pipe_defs.svh"

module stage_fetch (
    input  logic             clock,
    input  logic             reset,
    input  logic             bus_granted,
    input  logic             stall,
    input  logic             freeze,
    input  logic [`XLEN-1:0] fetch_data,
    output logic [`XLEN-1:0] fetch_pc,
    output logic             if_valid,
    output logic [`XLEN-1:0] if_pc,
    output logic [`XLEN-1:0] if_inst
);

    logic [`XLEN-1:0] pc;

    // Fetch request always goes out at the current PC
    assign fetch_pc = pc;

    always_ff @(posedge clock) begin
        if (reset) begin
            pc       <= '0;
            if_valid <= 1'b0;
            if_pc    <= '0;
            if_inst  <= `NOP;
        end else if (freeze) begin
            // Halt pending, nothing more issues
            if_valid <= 1'b0;
            if_inst  <= `NOP;
        end else if (stall) begin
            // Decode holds, keep IF/ID and PC
            if_valid <= if_valid;
        end else if (bus_granted) begin
            pc       <= pc + `XLEN'(`PC_STEP);
            if_valid <= 1'b1;
            if_pc    <= pc;
            if_inst  <= fetch_data;
        end else begin
            // Memory stage owns the bus this cycle
            if_valid <= 1'b0;
            if_inst  <= `NOP;
        end
    end

endmodule

// File: source/pipe_pkg.sv
// Shared types and RV32I encodings for the pipeline
// Only ADDI, ADD, SUB, LW, SW and WFI are decoded as legal
`include "pipe_defs.svh"

package pipe_pkg;

    ////////////////////////////////////////
    // Instruction word views
    ////////////////////////////////////////

    // Same 32-bit word, read as R, I or S form
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_form;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_form;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s_form;
    } instr_word_u;

    // Memory port command
    typedef enum logic [1:0] {
        bus_none  = 2'd0,
        bus_load  = 2'd1,
        bus_store = 2'd2
    } bus_command_e;

    // Halt code reported at commit
    typedef enum logic [1:0] {
        no_error      = 2'd0,
        illegal_inst  = 2'd1,
        halted_on_wfi = 2'd2
    } error_status_e;

    typedef enum logic [1:0] {
        alu_add = 2'd0,
        alu_sub = 2'd1
    } alu_op_e;

    ////////////////////////////////////////
    // Opcode and funct encodings
    ////////////////////////////////////////

    localparam logic [6:0] OP_IMM = 7'b001_0011;
    localparam logic [6:0] OP     = 7'b011_0011;
    localparam logic [6:0] LOAD   = 7'b000_0011;
    localparam logic [6:0] STORE  = 7'b010_0011;
    localparam logic [6:0] SYSTEM = 7'b111_0011;

    // ADD/ADDI share funct3, LW/SW use the word size
    localparam logic [2:0] FUNCT3_ADD  = 3'b000;
    localparam logic [2:0] FUNCT3_WORD = 3'b010;
    localparam logic [6:0] FUNCT7_ADD  = 7'b000_0000;
    localparam logic [6:0] FUNCT7_SUB  = 7'b010_0000;

    // WFI is one fixed SYSTEM word
    localparam logic [`XLEN-1:0] WFI_WORD = {12'h105, 5'd0, 3'b000, 5'd0, SYSTEM};

endpackage

// File: source/pipe_defs.svh
// Core widths and constants for the RV32I subset pipeline
// Register indices are 5 bits wide, so REG_COUNT must stay at 32
`ifndef PIPE_DEFS_SVH
`define PIPE_DEFS_SVH

////////////////////////////////////////
// Word and register file sizes
////////////////////////////////////////

// Data, address and instruction width
`define XLEN 32

// Architectural registers, x0 reads as zero
`define REG_COUNT 32

////////////////////////////////////////
// Fetch constants
////////////////////////////////////////

// ADDI x0,x0,0 used as the empty IF/ID word
`define NOP 32'h0000_0013

// Byte step between sequential instructions
`define PC_STEP 4

`endif
